// ==== files.f ====
hw/cart_pkg.sv
hw/cart_header.sv
hw/mbc_regs.sv
hw/mbc_map.sv
hw/cart_ram.sv
hw/backup_ctrl.sv
hw/cart_top.sv
sim/cart_tb.sv

// ==== Makefile ====
# cartridge core, Verilator flow

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module cart_tb -f files.f

sim:
	verilator --binary --timing -Wno-fatal --top-module cart_tb -f files.f \
		-Mdir obj_dir -o cart_sim
	-./obj_dir/cart_sim > sim.log 2>&1
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/cart_tb.sv ====
// cartridge subsystem testbench
`timescale 1ns/1ns

module cart_tb;

	localparam int WAIT_LIMIT = 1000;  // cycles before any wait gives up

	logic                 clk_sys = 1'b0;
	logic                 reset;
	logic                 dl_active_i, dl_wr_i;
	cart_pkg::dl_addr_t   dl_addr_i;
	cart_pkg::word_t      dl_data_i;
	logic                 ce_cpu2x_i, cart_rd_i, cart_wr_i;
	cart_pkg::cart_addr_t cart_addr_i;
	cart_pkg::cart_byte_t cart_di_i, cart_do_o;
	cart_pkg::word_t      rom_data_i;
	cart_pkg::rom_addr_t  rom_addr_o;
	logic                 img_mounted_i, img_readonly_i;
	logic [63:0]          img_size_i;
	logic                 load_req_i, save_req_i, osd_open_i, autosave_i;
	logic                 sd_ack_i, sd_buff_wr_i;
	logic [7:0]           sd_buff_addr_i;
	cart_pkg::word_t      sd_buff_dout_i, sd_buff_din_o;
	cart_pkg::sd_lba_t    sd_lba_o;
	logic                 sd_rd_o, sd_wr_o, save_pending_o, bk_busy_loading_o;

	logic [7:0]  ram_model [131072];  // expected cart ram, byte address

	cart_top cart_top_inst (.*);  // tb names match the port names

	always #2 clk_sys = ~clk_sys;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	// word address inside 16 KB banks
	function automatic logic [23:0] rom_word(input logic [8:0] bank, input logic [15:0] addr);
		return {2'b00, bank, addr[13:1]};
	endfunction

	task automatic download_header(input logic [7:0] type_code, input logic [7:0] rom_code,
		input logic [7:0] ram_code, input logic mount, input logic [63:0] size);
		@(negedge clk_sys);
		dl_active_i = 1'b1;
		img_size_i  = size;
		@(negedge clk_sys);
		img_mounted_i = mount;  // writable image shows up mid download
		@(negedge clk_sys);
		img_mounted_i = 1'b0;
		dl_addr_i     = cart_pkg::HDR_MBC_ADDR;
		dl_data_i     = {type_code, 8'h00};
		dl_wr_i       = 1'b1;
		@(negedge clk_sys);
		dl_addr_i = cart_pkg::HDR_SIZE_ADDR;
		dl_data_i = {ram_code, rom_code};
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		@(negedge clk_sys);
		dl_active_i = 1'b0;  // download end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		cart_addr_i = addr;
		cart_di_i   = data;
		cart_wr_i   = 1'b1;
		@(negedge clk_sys);
		cart_wr_i = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		@(negedge clk_sys);
		cart_addr_i = addr;
		cart_rd_i   = 1'b1;
		@(posedge clk_sys);
		#1;                  // ram output registered on this edge
		data = cart_do_o;
		@(negedge clk_sys);
		cart_rd_i = 1'b0;
	endtask

	task automatic rom_at(input string name, input logic [15:0] addr, input logic [23:0] exp);
		@(negedge clk_sys);
		cart_addr_i = addr;
		#1;
		check(name, 32'(exp), 32'(rom_addr_o));
	endtask

	// --------------------------------------------------
	// sd host side for one 512 byte block
	// --------------------------------------------------
	task automatic serve_block(input logic is_save, input int blk);
		int          cnt;
		int          i;
		int          idx;
		logic [15:0] w;
		cnt = 0;
		while (is_save ? !sd_wr_o : !sd_rd_o) begin
			@(negedge clk_sys);
			cnt++;
			if (cnt > WAIT_LIMIT)
				abort_run($sformatf("no sd request for block %0d", blk));
		end
		check("backup lba", 32'(blk), sd_lba_o);
		sd_ack_i = 1'b1;
		for (i = 0; i < 256; i++) begin
			idx            = blk * 256 + i;  // word index into the ram
			sd_buff_addr_i = 8'(i);
			if (!is_save) begin
				w                    = 16'($urandom);
				sd_buff_dout_i       = w;
				sd_buff_wr_i         = 1'b1;
				ram_model[2*idx]     = w[7:0];   // low byte is the even address
				ram_model[2*idx + 1] = w[15:8];
				@(negedge clk_sys);
			end else begin
				@(posedge clk_sys);
				#1;
				check("backup save word", 32'({ram_model[2*idx + 1], ram_model[2*idx]}),
					32'(sd_buff_din_o));
				@(negedge clk_sys);
			end
		end
		sd_buff_wr_i = 1'b0;
		check("backup request dropped", 32'b0, 32'(is_save ? sd_wr_o : sd_rd_o));
		sd_ack_i = 1'b0;  // falling ack ends the block
		@(negedge clk_sys);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_no_mbc();
		logic [15:0] a;
		logic [15:0] w;
		int          i;
		download_header(8'h00, 8'h00, 8'h00, 1'b0, 64'd0);
		rom_at("no_mbc addr 0000", 16'h0000, 24'h000000);
		rom_at("no_mbc addr 2abc", 16'h2ABC, {10'd0, 14'h155E});
		rom_at("no_mbc addr 4001", 16'h4001, {10'd0, 14'h2000});
		rom_at("no_mbc addr 7ffe", 16'h7FFE, {10'd0, 14'h3FFF});
		for (i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			w           = 16'($urandom);
			a           = 16'($urandom) & 16'h7FFF;
			rom_data_i  = w;
			cart_addr_i = a;
			cart_rd_i   = i[0];  // rom bytes show with or without a read
			#1;
			check("no_mbc rom byte", 32'(a[0] ? w[15:8] : w[7:0]), 32'(cart_do_o));
		end
		@(negedge clk_sys);
		cart_rd_i = 1'b0;
	endtask

	task automatic test_mbc1_banks();
		download_header(8'h01, 8'h03, 8'h00, 1'b0, 64'd0);
		rom_at("mbc1 bank 0 region", 16'h1234, rom_word(9'd0, 16'h1234));
		cpu_write(16'h2000, 8'd5);
		rom_at("mbc1 bank 5", 16'h4100, rom_word(9'd5, 16'h4100));
		cpu_write(16'h2000, 8'd0);  // zero selects bank 1
		rom_at("mbc1 bank zero", 16'h4000, rom_word(9'd1, 16'h4000));
		cpu_write(16'h2000, 8'd22);
		rom_at("mbc1 mirror", 16'h6002, rom_word(9'(22 & 15), 16'h6002));
		// bigger rom so the upper bank bits survive the mask
		download_header(8'h01, 8'h06, 8'h00, 1'b0, 64'd0);
		cpu_write(16'h2000, 8'd5);
		cpu_write(16'h4000, 8'd2);
		rom_at("mbc1 mode 0", 16'h5000, rom_word(9'h45, 16'h5000));
		cpu_write(16'h6000, 8'd1);
		rom_at("mbc1 mode 1", 16'h5000, rom_word(9'd5, 16'h5000));
	endtask

	task automatic test_mbc5_ram();
		int         bank;
		int         i;
		int         off;
		logic [7:0] d;
		download_header(8'h1B, 8'h08, 8'h03, 1'b0, 64'd0);
		cpu_write(16'h2000, 8'h34);
		cpu_write(16'h3000, 8'h01);
		rom_at("mbc5 bank 134", 16'h5678, rom_word(9'h134, 16'h5678));
		cpu_write(16'h2000, 8'h00);
		cpu_write(16'h3000, 8'h00);
		rom_at("mbc5 bank 0", 16'h4002, rom_word(9'd0, 16'h4002));
		cpu_write(16'h0000, 8'h0A);
		for (bank = 1; bank < 3; bank++) begin
			cpu_write(16'h4000, 8'(bank));
			for (i = 0; i < 16; i++) begin
				off = (i * 257) & 16'h1FFF;
				d   = 8'($urandom);
				cpu_write(16'hA000 | 16'(off), d);
				ram_model[bank * 8192 + off] = d;
			end
		end
		for (bank = 1; bank < 3; bank++) begin
			cpu_write(16'h4000, 8'(bank));
			for (i = 0; i < 16; i++) begin
				off = (i * 257) & 16'h1FFF;
				cpu_read(16'hA000 | 16'(off), d);
				check("mbc5 ram read", 32'(ram_model[bank * 8192 + off]), 32'(d));
			end
		end
		cpu_write(16'h0000, 8'h00);  // ram closed
		cpu_read(16'hA000, d);
		check("mbc5 ram disabled", 32'hFF, 32'(d));
	endtask

	task automatic test_mbc2_nibble();
		int         i;
		logic [7:0] d;
		logic [7:0] q;
		download_header(8'h06, 8'h00, 8'h00, 1'b0, 64'd0);
		cpu_write(16'h0000, 8'h0A);
		for (i = 0; i < 8; i++) begin
			d = 8'($urandom);
			cpu_write(16'hA000 + 16'(i * 61), d);
			cpu_read(16'hA000 + 16'(i * 61), q);
			check("mbc2 nibble", 32'({4'hF, d[3:0]}), 32'(q));
		end
	endtask

	task automatic test_backup();
		int         blk;
		int         cnt;
		int         off;
		logic [7:0] d;
		download_header(8'h1B, 8'h01, 8'h02, 1'b1, 64'd8192);
		for (blk = 0; blk < 16; blk++) begin
			serve_block(1'b0, blk);
			if (blk == 0)
				check("backup busy loading", 32'b1, 32'(bk_busy_loading_o));
		end
		cnt = 0;
		while (bk_busy_loading_o) begin
			@(negedge clk_sys);
			cnt++;
			if (cnt > WAIT_LIMIT)
				abort_run("load never finished after the last block");
		end
		check("backup pending idle", 32'b0, 32'(save_pending_o));
		// whole 8 KB bank back through the cpu port
		cpu_write(16'h0000, 8'h0A);
		for (off = 0; off < 8192; off++) begin
			cpu_read(16'hA000 + 16'(off), d);
			check("backup load readback", 32'(ram_model[off]), 32'(d));
		end
		off = int'($urandom) & 16'h1FFF;
		d   = 8'($urandom);
		cpu_write(16'hA000 + 16'(off), d);
		ram_model[off] = d;
		check("backup pending set", 32'b1, 32'(save_pending_o));
		@(negedge clk_sys);
		save_req_i = 1'b1;
		for (blk = 0; blk < 16; blk++) begin
			serve_block(1'b1, blk);
			check("backup pending cleared", 32'b0, 32'(save_pending_o));
		end
		repeat (4) begin
			@(negedge clk_sys);
			check("backup save done", 32'b0, 32'(sd_wr_o));
		end
		save_req_i = 1'b0;
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(32'h23d1_015e));
		reset          = 1'b1;
		dl_active_i    = 1'b0;
		dl_wr_i        = 1'b0;
		dl_addr_i      = '0;
		dl_data_i      = '0;
		ce_cpu2x_i     = 1'b1;  // cpu enable held on
		cart_addr_i    = '0;
		cart_rd_i      = 1'b0;
		cart_wr_i      = 1'b0;
		cart_di_i      = '0;
		rom_data_i     = '0;
		img_mounted_i  = 1'b0;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		load_req_i     = 1'b0;
		save_req_i     = 1'b0;
		osd_open_i     = 1'b0;
		autosave_i     = 1'b0;
		sd_ack_i       = 1'b0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i   = 1'b0;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
		check("reset sd_rd", 32'b0, 32'(sd_rd_o));
		check("reset sd_wr", 32'b0, 32'(sd_wr_o));
		check("reset pending", 32'b0, 32'(save_pending_o));
		check("reset loading", 32'b0, 32'(bk_busy_loading_o));
		test_no_mbc();
		test_mbc1_banks();
		test_mbc5_ram();
		test_mbc2_nibble();
		test_backup();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== hw/cart_top.sv ====
// cartridge subsystem top
`timescale 1ns/1ns

module cart_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	// rom download
	input  logic                  dl_active_i,
	input  logic                  dl_wr_i,
	input  cart_pkg::dl_addr_t    dl_addr_i,
	input  cart_pkg::word_t       dl_data_i,
	// cpu bus
	input  logic                  ce_cpu2x_i,
	input  cart_pkg::cart_addr_t  cart_addr_i,
	input  logic                  cart_rd_i,
	input  logic                  cart_wr_i,
	input  cart_pkg::cart_byte_t  cart_di_i,
	output cart_pkg::cart_byte_t  cart_do_o,
	// external rom
	input  cart_pkg::word_t       rom_data_i,
	output cart_pkg::rom_addr_t   rom_addr_o,
	// sd image
	input  logic                  img_mounted_i,
	input  logic                  img_readonly_i,
	input  logic [63:0]           img_size_i,
	input  logic                  load_req_i,
	input  logic                  save_req_i,
	input  logic                  osd_open_i,
	input  logic                  autosave_i,
	input  logic                  sd_ack_i,
	input  logic [7:0]            sd_buff_addr_i,
	input  cart_pkg::word_t       sd_buff_dout_i,
	input  logic                  sd_buff_wr_i,
	output cart_pkg::sd_lba_t     sd_lba_o,
	output logic                  sd_rd_o,
	output logic                  sd_wr_o,
	output cart_pkg::word_t       sd_buff_din_o,
	output logic                  save_pending_o,
	output logic                  bk_busy_loading_o  // holds the cpu in reset
);

	cart_pkg::mbc_kind_t  mbc_kind;
	cart_pkg::rom_bank_t  rom_mask;
	cart_pkg::ram_bank_t  ram_mask;
	cart_pkg::cart_byte_t ram_size_code;
	logic                 has_battery;
	cart_pkg::rom_bank_t  rom_bank;
	cart_pkg::ram_bank_t  ram_bank;
	logic                 mbc1_mode;
	logic                 rtc_mode;
	logic                 ram_enable;
	cart_pkg::cram_addr_t cram_addr;
	logic                 cram_wr;
	cart_pkg::cart_byte_t cram_q;
	logic                 bk_wr;

	cart_header cart_header_inst (
		.clk_sys, .reset, .dl_active_i, .dl_wr_i, .dl_addr_i, .dl_data_i,
		.mbc_kind_o(mbc_kind), .rom_mask_o(rom_mask), .ram_mask_o(ram_mask),
		.ram_size_code_o(ram_size_code), .has_battery_o(has_battery)
	);

	mbc_regs mbc_regs_inst (
		.clk_sys, .reset, .ce_cpu2x_i, .cart_wr_i, .dl_active_i,
		.loading_i(bk_busy_loading_o), .cart_addr_i, .cart_di_i, .mbc_kind_i(mbc_kind),
		.rom_bank_o(rom_bank), .ram_bank_o(ram_bank), .mbc1_mode_o(mbc1_mode),
		.rtc_mode_o(rtc_mode), .ram_enable_o(ram_enable)
	);

	mbc_map mbc_map_inst (
		.cart_addr_i, .mbc_kind_i(mbc_kind), .rom_bank_i(rom_bank), .rom_mask_i(rom_mask),
		.ram_bank_i(ram_bank), .ram_mask_i(ram_mask), .mbc1_mode_i(mbc1_mode),
		.rtc_mode_i(rtc_mode), .ram_enable_i(ram_enable), .rom_data_i, .cram_q_i(cram_q),
		.cart_rd_i, .cart_wr_i, .rom_addr_o, .cram_addr_o(cram_addr), .cram_wr_o(cram_wr),
		.cart_do_o
	);

	// sd buffer port comes straight from the host side
	cart_ram cart_ram_inst (
		.clk_sys, .ce_cpu2x_i, .cram_wr_i(cram_wr), .cram_addr_i(cram_addr), .cart_di_i,
		.cram_q_o(cram_q), .bk_lba_i(sd_lba_o), .sd_buff_addr_i, .sd_buff_dout_i,
		.bk_wr_i(bk_wr), .sd_buff_din_o
	);

	backup_ctrl backup_ctrl_inst (
		.clk_sys, .reset, .dl_active_i, .img_mounted_i, .img_readonly_i, .load_req_i,
		.save_req_i, .osd_open_i, .autosave_i, .sd_ack_i, .sd_buff_wr_i,
		.cram_wr_i(cram_wr), .has_battery_i(has_battery), .img_size_i,
		.mbc_kind_i(mbc_kind), .ram_size_code_i(ram_size_code), .sd_lba_o, .sd_rd_o,
		.sd_wr_o, .bk_wr_o(bk_wr), .save_pending_o, .loading_o(bk_busy_loading_o)
	);

endmodule

// ==== hw/backup_ctrl.sv ====
// backup ram save and load
`timescale 1ns/1ns

module backup_ctrl (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active_i,
	input  logic                  img_mounted_i,
	input  logic                  img_readonly_i,
	input  logic                  load_req_i,
	input  logic                  save_req_i,
	input  logic                  osd_open_i,
	input  logic                  autosave_i,
	input  logic                  sd_ack_i,
	input  logic                  sd_buff_wr_i,
	input  logic                  cram_wr_i,
	input  logic                  has_battery_i,
	input  logic [63:0]           img_size_i,
	input  cart_pkg::mbc_kind_t   mbc_kind_i,
	input  cart_pkg::cart_byte_t  ram_size_code_i,
	output cart_pkg::sd_lba_t     sd_lba_o,
	output logic                  sd_rd_o,
	output logic                  sd_wr_o,
	output logic                  bk_wr_o,
	output logic                  save_pending_o,
	output logic                  loading_o
);

	cart_pkg::bk_state_t state;
	logic       bk_ena;            // writable save image present
	logic       old_dl;
	logic       old_load;
	logic       old_save;
	logic       old_ack;
	logic       is_mbc2;
	logic       sav_supported;
	logic       save_lvl;          // menu request or autosave
	logic       dl_end;
	logic       start_load;
	logic       start_save;
	logic [7:0] file_mask;         // last block of the file

	assign is_mbc2       = (mbc_kind_i == cart_pkg::MBC_2);
	assign sav_supported = has_battery_i && (ram_size_code_i != 8'd0 || is_mbc2) && bk_ena;
	assign save_lvl      = save_req_i | (save_pending_o & osd_open_i & autosave_i);
	assign dl_end        = old_dl & ~dl_active_i;
	assign start_load    = (state == cart_pkg::BK_IDLE) && bk_ena &&
		((load_req_i & ~old_load) || (dl_end && |img_size_i));
	assign start_save    = (state == cart_pkg::BK_IDLE) && bk_ena && !start_load &&
		(save_lvl & ~old_save);
	assign bk_wr_o       = sd_buff_wr_i & sd_ack_i;  // only while the host is serving us
	assign loading_o     = (state == cart_pkg::BK_LOAD);

	always_comb begin
		if (is_mbc2)                    file_mask = 8'h01;  // 512 nibbles
		else if (ram_size_code_i == 8'd1) file_mask = 8'h03;
		else if (ram_size_code_i == 8'd2) file_mask = 8'h0F;
		else if (ram_size_code_i == 8'd3) file_mask = 8'h3F;
		else                            file_mask = 8'hFF;  // 128 KB
	end

	// --------------------------------------------------
	// enable, pending and edge history
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena         <= 1'b0;
			save_pending_o <= 1'b0;
			old_dl         <= 1'b0;
			old_load       <= 1'b0;
			old_save       <= 1'b0;
			old_ack        <= 1'b0;
		end else begin
			old_dl   <= dl_active_i;
			old_load <= load_req_i;
			old_save <= save_lvl;
			old_ack  <= sd_ack_i;
			if (dl_active_i && !old_dl)
				bk_ena <= 1'b0;                // new cart, forget old image
			if (dl_active_i && img_mounted_i && !img_readonly_i)
				bk_ena <= 1'b1;
			if (start_load || start_save)
				save_pending_o <= 1'b0;
			else if (cram_wr_i && !osd_open_i && sav_supported)
				save_pending_o <= 1'b1;        // ram differs from the file
		end
	end

	// --------------------------------------------------
	// block walker
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= cart_pkg::BK_IDLE;
			sd_lba_o <= '0;
			sd_rd_o  <= 1'b0;
			sd_wr_o  <= 1'b0;
		end else begin
			if (sd_ack_i && !old_ack) begin
				sd_rd_o <= 1'b0;  // host took the request
				sd_wr_o <= 1'b0;
			end
			if (start_load || start_save) begin
				state    <= start_load ? cart_pkg::BK_LOAD : cart_pkg::BK_SAVE;
				sd_lba_o <= '0;
				sd_rd_o  <= start_load;
				sd_wr_o  <= start_save;
			end else if (state != cart_pkg::BK_IDLE && old_ack && !sd_ack_i) begin
				if (sd_lba_o[7:0] >= file_mask) begin
					state <= cart_pkg::BK_IDLE;  // whole file done
				end else begin
					sd_lba_o <= sd_lba_o + 32'd1;
					sd_rd_o  <= (state == cart_pkg::BK_LOAD);
					sd_wr_o  <= (state == cart_pkg::BK_SAVE);
				end
			end
		end
	end

endmodule

// ==== hw/cart_ram.sv ====
// cartridge ram, two byte lanes
`timescale 1ns/1ns

module cart_ram (
	input  logic                  clk_sys,
	input  logic                  ce_cpu2x_i,
	input  logic                  cram_wr_i,
	input  cart_pkg::cram_addr_t  cram_addr_i,
	input  cart_pkg::cart_byte_t  cart_di_i,
	output cart_pkg::cart_byte_t  cram_q_o,
	input  cart_pkg::sd_lba_t     bk_lba_i,
	input  logic [7:0]            sd_buff_addr_i,
	input  cart_pkg::word_t       sd_buff_dout_i,
	input  logic                  bk_wr_i,
	output cart_pkg::word_t       sd_buff_din_o
);

	logic [7:0]  mem [2][65536];  // [0] even bytes, [1] odd bytes
	logic [15:0] cpu_a;           // word index on the cpu side
	logic [15:0] bk_a;            // word index on the sd side
	logic [1:0]  lane_we;
	logic [7:0]  cpu_q [2];
	logic        lane_q;          // registered lane select

	assign cpu_a      = cram_addr_i[16:1];
	assign bk_a       = {bk_lba_i[7:0], sd_buff_addr_i};  // 256 words per block
	assign lane_we[0] = ce_cpu2x_i & cram_wr_i & ~cram_addr_i[0];
	assign lane_we[1] = ce_cpu2x_i & cram_wr_i & cram_addr_i[0];

	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < 2; i++) begin
			if (lane_we[i])
				mem[i][cpu_a] <= cart_di_i;
			if (bk_wr_i)
				mem[i][bk_a] <= sd_buff_dout_i[8*i +: 8];  // low byte to even lane
			cpu_q[i]               <= mem[i][cpu_a];
			sd_buff_din_o[8*i +: 8] <= mem[i][bk_a];
		end
		lane_q <= cram_addr_i[0];
	end

	assign cram_q_o = lane_q ? cpu_q[1] : cpu_q[0];

endmodule

// ==== hw/mbc_map.sv ====
// cartridge address map and read mux
`timescale 1ns/1ns

module mbc_map (
	input  cart_pkg::cart_addr_t  cart_addr_i,
	input  cart_pkg::mbc_kind_t   mbc_kind_i,
	input  cart_pkg::rom_bank_t   rom_bank_i,
	input  cart_pkg::rom_bank_t   rom_mask_i,
	input  cart_pkg::ram_bank_t   ram_bank_i,
	input  cart_pkg::ram_bank_t   ram_mask_i,
	input  logic                  mbc1_mode_i,
	input  logic                  rtc_mode_i,
	input  logic                  ram_enable_i,
	input  cart_pkg::word_t       rom_data_i,
	input  cart_pkg::cart_byte_t  cram_q_i,
	input  logic                  cart_rd_i,
	input  logic                  cart_wr_i,
	output cart_pkg::rom_addr_t   rom_addr_o,
	output cart_pkg::cram_addr_t  cram_addr_o,
	output logic                  cram_wr_o,
	output cart_pkg::cart_byte_t  cart_do_o
);

	logic [6:0]           mbc1_bank;  // ram bank bits on top in mode 0
	cart_pkg::rom_bank_t  bank_sel;   // masked bank for 4000-7FFF
	logic [9:0]           page;       // 8 KB page into rom
	cart_pkg::ram_bank_t  ram_sel;
	cart_pkg::cart_byte_t cram_byte;
	logic                 is_cram;
	logic                 mbc2_nib;   // 512 x 4 bit ram on mbc2

	assign mbc1_bank = {mbc1_mode_i ? 2'b00 : ram_bank_i[1:0], rom_bank_i[4:0]};

	// --------------------------------------------------
	// rom banking
	// --------------------------------------------------
	always_comb begin
		case (mbc_kind_i)
			cart_pkg::MBC_1:                  bank_sel = {2'b00, mbc1_bank & rom_mask_i[6:0]};
			cart_pkg::MBC_2, cart_pkg::MBC_3: bank_sel = {2'b00, rom_bank_i[6:0] & rom_mask_i[6:0]};
			cart_pkg::MBC_5:                  bank_sel = rom_bank_i & rom_mask_i;
			default:                          bank_sel = '0;
		endcase

		if (mbc_kind_i == cart_pkg::MBC_NONE)
			page = {8'd0, cart_addr_i[14:13]};  // plain 32 KB
		else if (cart_addr_i[15:14] == 2'b00)
			page = {9'd0, cart_addr_i[13]};     // fixed bank 0
		else if (cart_addr_i[15:14] == 2'b01)
			page = {bank_sel, cart_addr_i[13]};
		else
			page = '0;
	end

	assign rom_addr_o = {2'b00, page, cart_addr_i[12:1]};

	// --------------------------------------------------
	// cart ram
	// --------------------------------------------------
	always_comb begin
		case (mbc_kind_i)
			cart_pkg::MBC_1:                  ram_sel = mbc1_mode_i ? ram_bank_i & ram_mask_i : '0;
			cart_pkg::MBC_3, cart_pkg::MBC_5: ram_sel = ram_bank_i & ram_mask_i;
			default:                          ram_sel = '0;
		endcase
	end

	assign is_cram     = (cart_addr_i[15:13] == cart_pkg::REGION_CRAM);
	assign cram_addr_o = {ram_sel, cart_addr_i[12:0]};
	assign cram_wr_o   = cart_wr_i & is_cram;
	assign mbc2_nib    = (mbc_kind_i == cart_pkg::MBC_2) && (cart_addr_i[15:9] == 7'b1010000);

	always_comb begin
		if (!ram_enable_i)
			cram_byte = 8'hFF;                 // closed ram floats high
		else if (mbc2_nib)
			cram_byte = {4'hF, cram_q_i[3:0]};
		else if (rtc_mode_i)
			cram_byte = 8'h00;                 // rtc not modelled
		else
			cram_byte = cram_q_i;
	end

	assign cart_do_o = (cart_rd_i && is_cram) ? cram_byte :
		cart_addr_i[0] ? rom_data_i[15:8] : rom_data_i[7:0];

endmodule

// ==== hw/mbc_regs.sv ====
// bank controller registers
`timescale 1ns/1ns

module mbc_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  ce_cpu2x_i,
	input  logic                  cart_wr_i,
	input  logic                  dl_active_i,
	input  logic                  loading_i,
	input  cart_pkg::cart_addr_t  cart_addr_i,
	input  cart_pkg::cart_byte_t  cart_di_i,
	input  cart_pkg::mbc_kind_t   mbc_kind_i,
	output cart_pkg::rom_bank_t   rom_bank_o,
	output cart_pkg::ram_bank_t   ram_bank_o,
	output logic                  mbc1_mode_o,
	output logic                  rtc_mode_o,
	output logic                  ram_enable_o
);

	logic is_mbc5;
	logic is_mbc3;

	assign is_mbc5 = (mbc_kind_i == cart_pkg::MBC_5);
	assign is_mbc3 = (mbc_kind_i == cart_pkg::MBC_3);

	always_ff @(posedge clk_sys) begin
		if (reset || dl_active_i || loading_i) begin
			rom_bank_o   <= 9'd1;  // bank 1 sits at 4000 out of reset
			ram_bank_o   <= '0;
			mbc1_mode_o  <= 1'b0;
			rtc_mode_o   <= 1'b0;
			ram_enable_o <= 1'b0;
		end else if (ce_cpu2x_i && cart_wr_i) begin
			case (cart_addr_i[15:13])
				cart_pkg::REGION_RAM_EN:
					ram_enable_o <= (cart_di_i[3:0] == cart_pkg::RAM_ENABLE_KEY);

				cart_pkg::REGION_ROM_BANK: begin
					if (is_mbc5) begin
						if (cart_addr_i[12])
							rom_bank_o[8] <= cart_di_i[0];     // 3000-3FFF, bit 8
						else
							rom_bank_o[7:0] <= cart_di_i;      // 2000-2FFF, zero allowed
					end else if (cart_di_i[6:0] == 7'd0) begin
						rom_bank_o <= 9'd1;                    // bank 0 reads as 1
					end else begin
						rom_bank_o <= {2'b00, cart_di_i[6:0]};
					end
				end

				cart_pkg::REGION_RAM_BANK: begin
					if (is_mbc3 && cart_di_i[3]) begin
						rtc_mode_o <= 1'b1;  // rtc register select
					end else if (is_mbc5) begin
						ram_bank_o <= cart_di_i[3:0];
					end else begin
						rtc_mode_o <= 1'b0;
						ram_bank_o <= {2'b00, cart_di_i[1:0]};
					end
				end

				// rom/ram mode select, only mbc1 has it
				cart_pkg::REGION_MODE:
					if (mbc_kind_i == cart_pkg::MBC_1)
						mbc1_mode_o <= cart_di_i[0];

				default: ;
			endcase
		end
	end

endmodule

// ==== hw/cart_header.sv ====
// cartridge header capture
`timescale 1ns/1ns

module cart_header (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active_i,
	input  logic                  dl_wr_i,
	input  cart_pkg::dl_addr_t    dl_addr_i,
	input  cart_pkg::word_t       dl_data_i,
	output cart_pkg::mbc_kind_t   mbc_kind_o,
	output cart_pkg::rom_bank_t   rom_mask_o,
	output cart_pkg::ram_bank_t   ram_mask_o,
	output cart_pkg::cart_byte_t  ram_size_code_o,
	output logic                  has_battery_o
);

	cart_pkg::cart_byte_t type_q;  // controller type byte
	cart_pkg::cart_byte_t rom_size_q;
	cart_pkg::cart_byte_t ram_size_q;

	// header words pass by during the download, grab the ones we need
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_q     <= '0;
			rom_size_q <= '0;
			ram_size_q <= '0;
		end else if (dl_active_i && dl_wr_i) begin
			if (dl_addr_i == cart_pkg::HDR_MBC_ADDR)
				type_q <= dl_data_i[15:8];
			if (dl_addr_i == cart_pkg::HDR_SIZE_ADDR) begin
				rom_size_q <= dl_data_i[7:0];   // low byte is rom code
				ram_size_q <= dl_data_i[15:8];  // high byte is ram code
			end
		end
	end

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	always_comb begin
		case (type_q)
			8'h01, 8'h02, 8'h03:                      mbc_kind_o = cart_pkg::MBC_1;
			8'h05, 8'h06:                             mbc_kind_o = cart_pkg::MBC_2;
			8'h0F, 8'h10, 8'h11, 8'h12, 8'h13:        mbc_kind_o = cart_pkg::MBC_3;
			8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E: mbc_kind_o = cart_pkg::MBC_5;
			default:                                  mbc_kind_o = cart_pkg::MBC_NONE;
		endcase

		// battery backed variants
		case (type_q)
			8'h03, 8'h06, 8'h09, 8'h0D, 8'h10,
			8'h13, 8'h1B, 8'h1E, 8'h22, 8'hFF: has_battery_o = 1'b1;
			default:                           has_battery_o = 1'b0;
		endcase

		case (rom_size_q)
			8'd0:    rom_mask_o = 9'h001;  // 32 KB, direct
			8'd1:    rom_mask_o = 9'h003;  // 4 banks
			8'd2:    rom_mask_o = 9'h007;
			8'd3:    rom_mask_o = 9'h00F;
			8'd4:    rom_mask_o = 9'h01F;
			8'd5:    rom_mask_o = 9'h03F;
			8'd6:    rom_mask_o = 9'h07F;  // 2 MB
			8'd7:    rom_mask_o = 9'h0FF;
			8'd8:    rom_mask_o = 9'h1FF;  // 8 MB
			default: rom_mask_o = 9'h07F;  // odd sizes 52..54 and the rest
		endcase

		if (ram_size_q < 8'd3)
			ram_mask_o = 4'h0;  // none, 2 KB or 8 KB, one bank
		else if (ram_size_q == 8'd3)
			ram_mask_o = 4'h3;  // 32 KB
		else
			ram_mask_o = 4'hF;  // 128 KB
	end

	assign ram_size_code_o = ram_size_q;

endmodule

// ==== hw/cart_pkg.sv ====
// cartridge shared definitions
package cart_pkg;

	// --------------------------------------------------
	// data widths
	// --------------------------------------------------
	typedef logic [15:0] cart_addr_t;  // cpu side cartridge address
	typedef logic [7:0]  cart_byte_t;  // cpu data byte
	typedef logic [15:0] word_t;       // download, rom and sd buffer word
	typedef logic [24:0] dl_addr_t;    // download byte address
	typedef logic [23:0] rom_addr_t;   // word address into external rom
	typedef logic [16:0] cram_addr_t;  // cart ram byte address, 128 KB
	typedef logic [8:0]  rom_bank_t;   // rom bank number or mask
	typedef logic [3:0]  ram_bank_t;   // ram bank number or mask
	typedef logic [31:0] sd_lba_t;     // sd block number

	// controller kind decoded from the header type byte
	typedef enum logic [2:0] {
		MBC_NONE,
		MBC_1,
		MBC_2,
		MBC_3,
		MBC_5
	} mbc_kind_t;

	// backup transfer state
	typedef enum logic [1:0] {
		BK_IDLE,
		BK_LOAD,
		BK_SAVE
	} bk_state_t;

	// --------------------------------------------------
	// header offsets in the rom image
	// --------------------------------------------------
	localparam dl_addr_t HDR_MBC_ADDR  = 25'h146;  // type in upper byte
	localparam dl_addr_t HDR_SIZE_ADDR = 25'h148;  // {ram code, rom code}

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;  // low nibble that opens ram

	// --------------------------------------------------
	// cpu register regions, cart address bits 15:13
	// --------------------------------------------------
	localparam logic [2:0] REGION_RAM_EN   = 3'd0;  // 0000-1FFF
	localparam logic [2:0] REGION_ROM_BANK = 3'd1;  // 2000-3FFF
	localparam logic [2:0] REGION_RAM_BANK = 3'd2;  // 4000-5FFF
	localparam logic [2:0] REGION_MODE     = 3'd3;  // 6000-7FFF
	localparam logic [2:0] REGION_CRAM     = 3'd5;  // A000-BFFF

endpackage
